// ==== Makefile ====
# Verilator build and run of the board harness testbench.
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_board_harness
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
rtl/board_pkg.sv
rtl/i2c_bus_resolve.sv
rtl/pin_loopback.sv
rtl/pin_breakout.sv
rtl/cheri_err_monitor.sv
rtl/board_harness.sv
verification/tb_clk_gen.sv
verification/tb_board_harness.sv

// ==== rtl/board_harness.sv ====
/*
  Board pin harness between the system pinmux and simple device signals.
  I2C, SPI, UART and RS485 are combinational. Loopback and CHERI capture
  each add one cycle.
*/
`timescale 1ns/100ps

module board_harness (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // System pinmux side.
  input  board_pkg::out_pins_t   out_to_pins_i,
  input  board_pkg::inout_pins_t inout_to_pins_i,
  input  board_pkg::inout_pins_t inout_to_pins_en_i,
  input  board_pkg::rs485_ctrl_t rs485_ctrl_i,
  output board_pkg::in_pins_t    in_from_pins_o,
  output board_pkg::inout_pins_t inout_from_pins_o,
  // Device side.
  input  board_pkg::i2c_lines_t  i2c_dev_i,
  output board_pkg::i2c_lines_t  i2c_ctrl_o,
  output board_pkg::spi_pins_t   spi_pmod_o,
  input  logic                   spi_cipo_i,
  input  logic                   uart_host_tx_i,
  output logic                   uart_dev_rx_o,
  input  logic                   rs485_dev_tx_i,
  output logic                   rs485_dev_rx_o,
  // CHERI error reporting.
  input  board_pkg::cheri_err_t  cheri_err_i,
  output board_pkg::cheri_err_t  cheri_seen_o,
  output board_pkg::cheri_err_t  cheri_new_o
);

  // Resolved I2C bus values.
  board_pkg::i2c_lines_t i2c_bus;
  // Retimed loopback bits.
  board_pkg::loopback_t  loopback;

  i2c_bus_resolve u_i2c_bus_resolve (
    .inout_to_pins_i   (inout_to_pins_i),
    .inout_to_pins_en_i(inout_to_pins_en_i),
    .i2c_dev_i         (i2c_dev_i),
    .i2c_ctrl_o        (i2c_ctrl_o),
    .i2c_bus_o         (i2c_bus)
  );

  pin_loopback u_pin_loopback (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .out_to_pins_i  (out_to_pins_i),
    .inout_to_pins_i(inout_to_pins_i),
    .loopback_o     (loopback)
  );

  pin_breakout u_pin_breakout (
    .out_to_pins_i     (out_to_pins_i),
    .inout_to_pins_i   (inout_to_pins_i),
    .inout_to_pins_en_i(inout_to_pins_en_i),
    .rs485_ctrl_i      (rs485_ctrl_i),
    .i2c_bus_i         (i2c_bus),
    .loopback_i        (loopback),
    .spi_cipo_i        (spi_cipo_i),
    .uart_host_tx_i    (uart_host_tx_i),
    .rs485_dev_tx_i    (rs485_dev_tx_i),
    .spi_pmod_o        (spi_pmod_o),
    .uart_dev_rx_o     (uart_dev_rx_o),
    .rs485_dev_rx_o    (rs485_dev_rx_o),
    .in_from_pins_o    (in_from_pins_o),
    .inout_from_pins_o (inout_from_pins_o)
  );

  cheri_err_monitor u_cheri_err_monitor (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cheri_err_i (cheri_err_i),
    .cheri_seen_o(cheri_seen_o),
    .cheri_new_o (cheri_new_o)
  );

endmodule

// ==== rtl/board_pkg.sv ====
/*
  Shared pin-vector types for the board harness. Pin vectors are indexed by
  the enums below. Only the pins the harness routes are listed.
*/
package board_pkg;

  // Widths of the three pinmux vectors.
  localparam int unsigned OutPinCount   = 5;
  localparam int unsigned InPinCount    = 4;
  localparam int unsigned InoutPinCount = 19;

  // Number of I2C buses: 0 is HAT ID, 1 is HAT secondary, 2 is QWIIC1.
  localparam int unsigned I2cBusCount   = 3;
  // One error line per CHERI exception type.
  localparam int unsigned CheriErrWidth = 9;
  // Number of registered loopback paths.
  localparam int unsigned LoopbackCount = 6;

  typedef enum logic [2:0] {SER0_TX, RS485_TX, MB4, MB7, MB10} out_pin_e;
  typedef enum logic [1:0] {SER0_RX, RS485_RX, MB3, MB8} in_pin_e;

  // Bidirectional pins; order sets the bit position in the vector.
  typedef enum logic [4:0] {
    RPH_G0, RPH_G1, RPH_G2_SDA, RPH_G3_SCL, SCL0, SDA0, SCL1, SDA1,
    PMOD1_1, PMOD1_2, PMOD1_3, PMOD1_4, PMOD0_1, PMOD0_8, PMOD0_10,
    AH_TMPIO0, AH_TMPIO1, AH_TMPIO8, AH_TMPIO9
  } inout_pin_e;

  typedef logic [OutPinCount-1:0]   out_pins_t;
  typedef logic [InPinCount-1:0]    in_pins_t;
  typedef logic [InoutPinCount-1:0] inout_pins_t;

  // Inout pins carrying each bus's clock and data, indexed by bus.
  localparam inout_pin_e I2cSclPin [I2cBusCount] = '{RPH_G1, RPH_G3_SCL, SCL1};
  localparam inout_pin_e I2cSdaPin [I2cBusCount] = '{RPH_G0, RPH_G2_SDA, SDA1};

  typedef struct packed {
    logic scl;
    logic sda;
  } i2c_line_t;

  typedef i2c_line_t [I2cBusCount-1:0] i2c_lines_t;

  // PMOD1 SPI controller outputs.
  typedef struct packed {
    logic sck;
    logic cs;
    logic copi;
  } spi_pins_t;

  typedef struct packed {
    logic tx_en;
    logic rx_en;
  } rs485_ctrl_t;

  typedef enum logic [3:0] {
    BOUNDS, TAG, SEAL, PERMIT_EXEC, PERMIT_LOAD, PERMIT_STORE,
    PERMIT_STORE_CAP, PERMIT_STORE_LOCAL_CAP, PERMIT_ACC_SYS_REGS
  } cheri_err_e;

  typedef logic [CheriErrWidth-1:0] cheri_err_t;
  typedef logic [LoopbackCount-1:0] loopback_t;

endpackage

// ==== rtl/cheri_err_monitor.sv ====
/*
  Sticky capture of CHERI error lines. The lines are modulated for LEDs,
  so only the first assertion of each bit after reset pulses cheri_new_o.
*/
`timescale 1ns/100ps

module cheri_err_monitor (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  board_pkg::cheri_err_t cheri_err_i,
  output board_pkg::cheri_err_t cheri_seen_o,
  output board_pkg::cheri_err_t cheri_new_o
);

  // Errors seen since reset.
  board_pkg::cheri_err_t seen_q;
  // One-cycle first-occurrence pulses.
  board_pkg::cheri_err_t new_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_q <= '0;
      new_q  <= '0;
    end else begin
      // Accumulate every bit that has been high.
      seen_q <= seen_q | cheri_err_i;
      // Pulse only bits not yet recorded.
      // Several may fire on the same edge.
      new_q  <= cheri_err_i & ~seen_q;
    end
  end

  assign cheri_seen_o = seen_q;
  assign cheri_new_o  = new_q;

endmodule

// ==== rtl/i2c_bus_resolve.sv ====
/*
  Open-drain resolution of the three I2C buses as a wired-AND.
  An undriven controller pin reads as pulled up. Purely combinational.
*/
`timescale 1ns/100ps

module i2c_bus_resolve (
  input  board_pkg::inout_pins_t inout_to_pins_i,
  input  board_pkg::inout_pins_t inout_to_pins_en_i,
  input  board_pkg::i2c_lines_t  i2c_dev_i,
  output board_pkg::i2c_lines_t  i2c_ctrl_o,
  output board_pkg::i2c_lines_t  i2c_bus_o
);

  // Controller side of each bus after the pull-up default.
  board_pkg::i2c_lines_t ctrl;

  for (genvar b = 0; b < board_pkg::I2cBusCount; b++) begin : g_bus
    // Clock line follows the pin only while the controller drives it.
    assign ctrl[b].scl = inout_to_pins_en_i[board_pkg::I2cSclPin[b]] ?
                         inout_to_pins_i[board_pkg::I2cSclPin[b]] : 1'b1;

    // Data line, same pull-up rule.
    assign ctrl[b].sda = inout_to_pins_en_i[board_pkg::I2cSdaPin[b]] ?
                         inout_to_pins_i[board_pkg::I2cSdaPin[b]] : 1'b1;

    // The bus value includes the controller's own drive.
    // Otherwise it would see its transmissions as contention.
    assign i2c_bus_o[b].scl = ctrl[b].scl & i2c_dev_i[b].scl;
    assign i2c_bus_o[b].sda = ctrl[b].sda & i2c_dev_i[b].sda;
  end

  // Devices see only the controller side.
  assign i2c_ctrl_o = ctrl;

endmodule

// ==== rtl/pin_breakout.sv ====
/*
  SPI PMOD outputs, UART and half-duplex RS485 routing, and the vectors
  returned to the pinmux. Unsourced returned pins read as 1.
*/
`timescale 1ns/100ps

module pin_breakout (
  input  board_pkg::out_pins_t   out_to_pins_i,
  input  board_pkg::inout_pins_t inout_to_pins_i,
  input  board_pkg::inout_pins_t inout_to_pins_en_i,
  input  board_pkg::rs485_ctrl_t rs485_ctrl_i,
  input  board_pkg::i2c_lines_t  i2c_bus_i,
  input  board_pkg::loopback_t   loopback_i,
  input  logic                   spi_cipo_i,
  input  logic                   uart_host_tx_i,
  input  logic                   rs485_dev_tx_i,
  output board_pkg::spi_pins_t   spi_pmod_o,
  output logic                   uart_dev_rx_o,
  output logic                   rs485_dev_rx_o,
  output board_pkg::in_pins_t    in_from_pins_o,
  output board_pkg::inout_pins_t inout_from_pins_o
);

  // SPI outputs idle high when the pin is not enabled.
  assign spi_pmod_o.cs   = inout_to_pins_en_i[board_pkg::PMOD1_1] ?
                           inout_to_pins_i[board_pkg::PMOD1_1] : 1'b1;
  assign spi_pmod_o.copi = inout_to_pins_en_i[board_pkg::PMOD1_2] ?
                           inout_to_pins_i[board_pkg::PMOD1_2] : 1'b1;
  assign spi_pmod_o.sck  = inout_to_pins_en_i[board_pkg::PMOD1_4] ?
                           inout_to_pins_i[board_pkg::PMOD1_4] : 1'b1;

  // System UART transmit goes straight to the device.
  assign uart_dev_rx_o = out_to_pins_i[board_pkg::SER0_TX];

  // RS485 driver only passes data while transmit is enabled.
  assign rs485_dev_rx_o = rs485_ctrl_i.tx_en ? out_to_pins_i[board_pkg::RS485_TX] : 1'b1;

  // Input pins returned to the system.
  always_comb begin
    in_from_pins_o = '1;
    in_from_pins_o[board_pkg::SER0_RX] = uart_host_tx_i;
    // Receiver is idle high unless enabled.
    in_from_pins_o[board_pkg::RS485_RX] = rs485_ctrl_i.rx_en ? rs485_dev_tx_i : 1'b1;
    // mikroBUS SPI and UART loopbacks.
    in_from_pins_o[board_pkg::MB3] = loopback_i[0];
    in_from_pins_o[board_pkg::MB8] = loopback_i[1];
  end

  // Inout pins returned to the system.
  always_comb begin
    // Pulled up on the board when nothing drives them, SCL0 and SDA0 included.
    inout_from_pins_o = '1;

    // Resolved I2C bus values back onto their pins.
    for (int b = 0; b < board_pkg::I2cBusCount; b++) begin
      inout_from_pins_o[board_pkg::I2cSclPin[b]] = i2c_bus_i[b].scl;
      inout_from_pins_o[board_pkg::I2cSdaPin[b]] = i2c_bus_i[b].sda;
    end

    // PMOD1 SPI data in.
    inout_from_pins_o[board_pkg::PMOD1_3] = spi_cipo_i;

    // Remaining loopback destinations.
    inout_from_pins_o[board_pkg::PMOD0_1]   = loopback_i[2];
    inout_from_pins_o[board_pkg::PMOD0_10]  = loopback_i[3];
    inout_from_pins_o[board_pkg::AH_TMPIO0] = loopback_i[4];
    inout_from_pins_o[board_pkg::AH_TMPIO9] = loopback_i[5];
  end

endmodule

// ==== rtl/pin_loopback.sv ====
/*
  One register stage on each pin loopback path. Breaks the vector-level
  loop through the pinmux, so each destination lags its source by a cycle.
*/
`timescale 1ns/100ps

module pin_loopback (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  board_pkg::out_pins_t   out_to_pins_i,
  input  board_pkg::inout_pins_t inout_to_pins_i,
  output board_pkg::loopback_t   loopback_o
);

  board_pkg::loopback_t loopback_q;

  // Bit order matches the destinations in pin_breakout.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loopback_q <= '0;
    end else begin
      // mikroBUS COPI to CIPO, SPI loopback.
      loopback_q[0] <= out_to_pins_i[board_pkg::MB4];
      // mikroBUS TX to RX, UART loopback.
      loopback_q[1] <= out_to_pins_i[board_pkg::MB7];
      // mikroBUS PWM to PMOD0 pin 1.
      loopback_q[2] <= out_to_pins_i[board_pkg::MB10];
      // PMOD0 pin 8 to pin 10, PWM loopback.
      loopback_q[3] <= inout_to_pins_i[board_pkg::PMOD0_8];
      // Arduino header pairs.
      loopback_q[4] <= inout_to_pins_i[board_pkg::AH_TMPIO1];
      loopback_q[5] <= inout_to_pins_i[board_pkg::AH_TMPIO8];
    end
  end

  assign loopback_o = loopback_q;

endmodule

// ==== verification/tb_board_harness.sv ====
/*
  Testbench for the board harness. Each table row carries its stimulus and
  the outputs that the pin rules predict for it. Rows change on the rising
  edge and outputs are compared at the falling edge.
*/
`timescale 1ns/100ps

module tb_board_harness;

  localparam int ResetCycles = 8;
  localparam int RowCount    = 40;
  // One row per cycle, so twice the table plus reset is ample.
  localparam int CycleLimit  = 2 * RowCount + ResetCycles;

  // Inputs of one row, in the order of the table columns.
  typedef struct packed {
    board_pkg::out_pins_t   out_pins;
    board_pkg::inout_pins_t inout_pins;
    board_pkg::inout_pins_t inout_en;
    board_pkg::rs485_ctrl_t rs485_ctrl;
    board_pkg::i2c_lines_t  i2c_dev;
    logic                   spi_cipo;
    logic                   uart_host_tx;
    logic                   rs485_dev_tx;
    board_pkg::cheri_err_t  cheri_err;
  } stim_t;

  // Outputs expected while that row is applied.
  typedef struct packed {
    board_pkg::i2c_lines_t  i2c_ctrl;
    board_pkg::spi_pins_t   spi;
    logic                   uart_rx;
    logic                   rs485_rx;
    board_pkg::in_pins_t    in_pins;
    board_pkg::inout_pins_t inout_pins;
    board_pkg::cheri_err_t  seen;
    board_pkg::cheri_err_t  fresh;
  } want_t;

  logic                   clk;
  logic                   rst_n;
  stim_t                  stim;
  board_pkg::in_pins_t    in_from_pins;
  board_pkg::inout_pins_t inout_from_pins;
  board_pkg::i2c_lines_t  i2c_ctrl;
  board_pkg::spi_pins_t   spi_pmod;
  logic                   uart_dev_rx;
  logic                   rs485_dev_rx;
  board_pkg::cheri_err_t  cheri_seen;
  board_pkg::cheri_err_t  cheri_new;

  stim_t                 stims [RowCount];
  want_t                 wants [RowCount];
  int                    row_count;
  int                    cur_row;
  // Sticky CHERI record of the reference model.
  board_pkg::cheri_err_t seen_ref;
  integer                seed;
  int                    cycle_count = 0;

  tb_clk_gen #(.ResetCycles(ResetCycles)) u_clk_gen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  board_harness u_dut (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .out_to_pins_i     (stim.out_pins),
    .inout_to_pins_i   (stim.inout_pins),
    .inout_to_pins_en_i(stim.inout_en),
    .rs485_ctrl_i      (stim.rs485_ctrl),
    .in_from_pins_o    (in_from_pins),
    .inout_from_pins_o (inout_from_pins),
    .i2c_dev_i         (stim.i2c_dev),
    .i2c_ctrl_o        (i2c_ctrl),
    .spi_pmod_o        (spi_pmod),
    .spi_cipo_i        (stim.spi_cipo),
    .uart_host_tx_i    (stim.uart_host_tx),
    .uart_dev_rx_o     (uart_dev_rx),
    .rs485_dev_tx_i    (stim.rs485_dev_tx),
    .rs485_dev_rx_o    (rs485_dev_rx),
    .cheri_err_i       (stim.cheri_err),
    .cheri_seen_o      (cheri_seen),
    .cheri_new_o       (cheri_new)
  );

  task automatic stop_run(input string reason);
    $display("sim failed");
    $fatal(1, "%s", reason);
  endtask

  task automatic report_value(input string name, input logic [31:0] got, want);
    $display("[FAIL] %s row %0d got 0x%0h expected 0x%0h", name, cur_row, got, want);
    stop_run("an output did not match its expected value");
  endtask

  task automatic check_i2c(input string name, input board_pkg::i2c_lines_t got, want);
    if (got !== want) report_value(name, 32'(got), 32'(want));
  endtask

  task automatic check_spi(input string name, input board_pkg::spi_pins_t got, want);
    if (got !== want) report_value(name, 32'(got), 32'(want));
  endtask

  task automatic check_in_pins(input string name, input board_pkg::in_pins_t got, want);
    if (got !== want) report_value(name, 32'(got), 32'(want));
  endtask

  task automatic check_inout_pins(input string name, input board_pkg::inout_pins_t got, want);
    if (got !== want) report_value(name, 32'(got), 32'(want));
  endtask

  task automatic check_cheri(input string name, input board_pkg::cheri_err_t got, want);
    if (got !== want) report_value(name, 32'(got), 32'(want));
  endtask

  task automatic check_bit(input string name, input logic got, want);
    if (got !== want) report_value(name, 32'(got), 32'(want));
  endtask

  // Appends a row with the outputs that the pin rules predict for it.
  task automatic add_row(input stim_t s);
    stim_t                  prev;
    board_pkg::inout_pins_t pulled;
    board_pkg::i2c_lines_t  bus;
    want_t                  w;
    // Loopback and CHERI outputs lag one row. Before the first row all is zero.
    prev = '0;
    if (row_count > 0) begin
      prev = stims[row_count-1];
    end
    // Undriven pins read high through the board pull-ups.
    pulled = s.inout_pins | ~s.inout_en;
    w.i2c_ctrl[0] = {pulled[board_pkg::RPH_G1], pulled[board_pkg::RPH_G0]};
    w.i2c_ctrl[1] = {pulled[board_pkg::RPH_G3_SCL], pulled[board_pkg::RPH_G2_SDA]};
    w.i2c_ctrl[2] = {pulled[board_pkg::SCL1], pulled[board_pkg::SDA1]};
    // Open drain, so either side can pull a line low.
    bus = w.i2c_ctrl & s.i2c_dev;
    w.spi = {pulled[board_pkg::PMOD1_4], pulled[board_pkg::PMOD1_1],
             pulled[board_pkg::PMOD1_2]};
    w.uart_rx  = s.out_pins[board_pkg::SER0_TX];
    w.rs485_rx = s.rs485_ctrl.tx_en ? s.out_pins[board_pkg::RS485_TX] : 1'b1;
    // MB8, MB3, RS485_RX and SER0_RX from the top bit down.
    w.in_pins = {prev.out_pins[board_pkg::MB7], prev.out_pins[board_pkg::MB4],
                 s.rs485_ctrl.rx_en ? s.rs485_dev_tx : 1'b1, s.uart_host_tx};
    w.inout_pins = '1;
    w.inout_pins[board_pkg::RPH_G1]     = bus[0].scl;
    w.inout_pins[board_pkg::RPH_G0]     = bus[0].sda;
    w.inout_pins[board_pkg::RPH_G3_SCL] = bus[1].scl;
    w.inout_pins[board_pkg::RPH_G2_SDA] = bus[1].sda;
    w.inout_pins[board_pkg::SCL1]       = bus[2].scl;
    w.inout_pins[board_pkg::SDA1]       = bus[2].sda;
    w.inout_pins[board_pkg::PMOD1_3]    = s.spi_cipo;
    w.inout_pins[board_pkg::PMOD0_1]    = prev.out_pins[board_pkg::MB10];
    w.inout_pins[board_pkg::PMOD0_10]   = prev.inout_pins[board_pkg::PMOD0_8];
    w.inout_pins[board_pkg::AH_TMPIO0]  = prev.inout_pins[board_pkg::AH_TMPIO1];
    w.inout_pins[board_pkg::AH_TMPIO9]  = prev.inout_pins[board_pkg::AH_TMPIO8];
    // A bit pulses only if no earlier row had it set.
    w.fresh  = prev.cheri_err & ~seen_ref;
    seen_ref = seen_ref | prev.cheri_err;
    w.seen   = seen_ref;
    stims[row_count] = s;
    wants[row_count] = w;
    row_count++;
  endtask

  task automatic check_row(input int r);
    cur_row = r;
    check_i2c("i2c_ctrl_o", i2c_ctrl, wants[r].i2c_ctrl);
    check_spi("spi_pmod_o", spi_pmod, wants[r].spi);
    check_bit("uart_dev_rx_o", uart_dev_rx, wants[r].uart_rx);
    check_bit("rs485_dev_rx_o", rs485_dev_rx, wants[r].rs485_rx);
    check_in_pins("in_from_pins_o", in_from_pins, wants[r].in_pins);
    check_inout_pins("inout_from_pins_o", inout_from_pins, wants[r].inout_pins);
    check_cheri("cheri_seen_o", cheri_seen, wants[r].seen);
    check_cheri("cheri_new_o", cheri_new, wants[r].fresh);
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > CycleLimit) begin
      $display("Timed out after %0d cycles before the table was finished.", CycleLimit);
      stop_run("timeout");
    end
  end

  initial begin : stimulus
    logic [31:0] r0, r1, r2, r3;
    seed      = 32'h8df5;
    row_count = 0;
    cur_row   = 0;
    seen_ref  = '0;
    // Row columns are out pins, inout pins, inout enables, RS485 tx_en and rx_en,
    // I2C device lines, CIPO, UART tx, RS485 tx and CHERI errors.
    // Idle row, also held through reset.
    add_row({5'h00, 19'h00000, 19'h00000, 2'b00, 6'h3f, 1'b0, 1'b1, 1'b1, 9'h000});
    // I2C pins driven low, then high against device pull-downs.
    add_row({5'h00, 19'h00000, 19'h000cf, 2'b00, 6'h3f, 1'b0, 1'b1, 1'b1, 9'h001});
    add_row({5'h00, 19'h000cf, 19'h000cf, 2'b00, 6'h2d, 1'b0, 1'b1, 1'b1, 9'h000});
    // Only some clock pins driven.
    add_row({5'h00, 19'h00000, 19'h0004a, 2'b00, 6'h17, 1'b0, 1'b1, 1'b1, 9'h001});
    // PMOD1 SPI enabled with two patterns, then released.
    add_row({5'h00, 19'h00900, 19'h00b00, 2'b00, 6'h3f, 1'b1, 1'b1, 1'b1, 9'h000});
    add_row({5'h00, 19'h00200, 19'h00b00, 2'b00, 6'h3f, 1'b0, 1'b1, 1'b1, 9'h006});
    add_row({5'h00, 19'h00000, 19'h00000, 2'b00, 6'h3f, 1'b1, 1'b1, 1'b1, 9'h000});
    // UART and RS485 through each enable combination.
    add_row({5'h01, 19'h00000, 19'h00000, 2'b10, 6'h3f, 1'b0, 1'b0, 1'b0, 9'h006});
    add_row({5'h02, 19'h00000, 19'h00000, 2'b10, 6'h3f, 1'b0, 1'b1, 1'b0, 9'h000});
    add_row({5'h02, 19'h00000, 19'h00000, 2'b01, 6'h3f, 1'b0, 1'b0, 1'b0, 9'h1f0});
    add_row({5'h00, 19'h00000, 19'h00000, 2'b11, 6'h3f, 1'b0, 1'b1, 1'b1, 9'h000});
    add_row({5'h00, 19'h00000, 19'h00000, 2'b00, 6'h3f, 1'b0, 1'b0, 1'b0, 9'h1f0});
    // Loopback sources toggled row by row.
    add_row({5'h1c, 19'h32000, 19'h00000, 2'b00, 6'h3f, 1'b0, 1'b1, 1'b1, 9'h100});
    add_row({5'h14, 19'h22000, 19'h00000, 2'b00, 6'h3f, 1'b0, 1'b1, 1'b1, 9'h000});
    add_row({5'h08, 19'h12000, 19'h00000, 2'b00, 6'h3f, 1'b0, 1'b1, 1'b1, 9'h1ff});
    add_row({5'h00, 19'h00000, 19'h00000, 2'b00, 6'h3f, 1'b0, 1'b1, 1'b1, 9'h1ff});
    // Random rows fill the rest. Errors are kept sparse.
    while (row_count < RowCount) begin
      r0 = $random(seed);
      r1 = $random(seed);
      r2 = $random(seed);
      r3 = $random(seed);
      add_row({r0[4:0], r0[23:5], r1[18:0], r1[20:19], r1[26:21], r2[2:0],
               r2[11:3] & r3[8:0]});
    end
    stim <= stims[0];
    wait (rst_n === 1'b1);
    // State right after reset matches the idle row.
    check_row(0);
    for (int r = 1; r < RowCount; r++) begin
      @(posedge clk);
      stim <= stims[r];
      @(negedge clk);
      check_row(r);
    end
    $display("sim passed");
    $finish;
  end

endmodule

// ==== verification/tb_clk_gen.sv ====
/*
  Free-running 20 ns clock. Reset is held low for ResetCycles rising
  edges and released on the following falling edge.
*/
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #10 clk_o = ~clk_o;
    end
  end

  // Release away from the rising edge.
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule
